//--- run.sh
#!/bin/sh
# build the free list testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f verilog.f --top-module specFreeListTb \
  -Mdir "$BUILD_DIR" -o specFreeListTb
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$BUILD_DIR/specFreeListTb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Simulation failed" "$LOG"; then
  exit 1
fi
exit 0

//--- sim/specFreeListTb.sv
module specFreeListTb;

  timeunit 1ns;
  timeprecision 100ps;

  // the tests need a few hundred cycles including init, this leaves ample margin
  localparam int CycleLimit = 1000;

  logic                                                 clk;
  logic                                                 reset;
  logic                                                 stall;
  logic                                                 recover;
  logic [flPkg::DispatchWidth-1:0]                      reqPhyReg;
  logic [flPkg::CommitWidth-1:0]                        freedValid;
  logic [flPkg::CommitWidth-1:0][flPkg::PhysRegW-1:0]   freedRegId;
  logic [flPkg::DispatchWidth-1:0][flPkg::PhysRegW-1:0] freePhyReg;
  logic                                                 freeListEmpty;
  logic                                                 flRamReady;

  // reference copy of the circular list
  logic [flPkg::PhysRegW-1:0] refMem [flPkg::FreeListSize];
  int                         refHead;
  int                         refTail;
  int                         refCount;
  // tags handed to rename and not yet returned by commit
  logic [flPkg::PhysRegW-1:0] heldTags [$];

  int errorCount;
  int testsPassed;
  int testsFailed;
  int cycleCount;
  int seed;

  specFreeList specFreeList_i
  (
    .clk             (clk),
    .reset           (reset),
    .stall_i         (stall),
    .recover_i       (recover),
    .reqPhyReg_i     (reqPhyReg),
    .freedValid_i    (freedValid),
    .freedRegId_i    (freedRegId),
    .freePhyReg_o    (freePhyReg),
    .freeListEmpty_o (freeListEmpty),
    .flRamReady_o    (flRamReady)
  );

  always #20 clk = ~clk;

  task automatic checkTag(input string name, input logic [flPkg::PhysRegW-1:0] got,
                          input logic [flPkg::PhysRegW-1:0] expected);
    if (got !== expected)
    begin
      $display("CHECK FAILED %s got 0x%h expected 0x%h", name, got, expected);
      errorCount++;
    end
  endtask

  task automatic checkFlag(input string name, input logic got, input logic expected);
    if (got !== expected)
    begin
      $display("CHECK FAILED %s got 0x%h expected 0x%h", name, got, expected);
      errorCount++;
    end
  endtask

  task automatic resetModel();
    for (int i = 0; i < flPkg::FreeListSize; i++)
    begin
      refMem[i] = flPkg::PhysRegW'(flPkg::NumArchRegs + i);
    end
    refHead  = 0;
    refTail  = 0;
    refCount = flPkg::FreeListSize;
    heldTags.delete();
  endtask

  // outputs depend on registered state only, so they are compared mid cycle
  task automatic compareToModel();
    logic                       isEmpty;
    logic [flPkg::PhysRegW-1:0] expTag;
    isEmpty = (refCount < flPkg::DispatchWidth);
    checkFlag("flRamReady_o", flRamReady, 1'b1);
    checkFlag("freeListEmpty_o", freeListEmpty, isEmpty);
    for (int i = 0; i < flPkg::DispatchWidth; i++)
    begin
      expTag = isEmpty ? '0 : refMem[(refHead + i) % flPkg::FreeListSize];
      checkTag($sformatf("freePhyReg_o[%0d]", i), freePhyReg[i], expTag);
    end
  endtask

  task automatic advanceModel(input logic [flPkg::DispatchWidth-1:0] req, input logic stallIn,
                              input logic recIn, input logic [flPkg::CommitWidth-1:0] valid,
                              input logic [flPkg::CommitWidth-1:0][flPkg::PhysRegW-1:0] ids);
    int   pops;
    int   pushes;
    int   oldTail;
    logic popOk;
    pops = 0;
    for (int i = 0; i < flPkg::DispatchWidth; i++)
    begin
      pops += int'(req[i]);
    end
    popOk   = !stallIn && (refCount >= flPkg::DispatchWidth);
    oldTail = refTail;
    // popped tags leave before the frees land
    if (popOk && !recIn)
    begin
      for (int i = 0; i < pops; i++)
      begin
        heldTags.push_back(refMem[(refHead + i) % flPkg::FreeListSize]);
      end
    end
    pushes = 0;
    for (int lane = 0; lane < flPkg::CommitWidth; lane++)
    begin
      if (valid[lane])
      begin
        refMem[(refTail + pushes) % flPkg::FreeListSize] = ids[lane];
        pushes++;
      end
    end
    refTail = (refTail + pushes) % flPkg::FreeListSize;
    if (recIn)
    begin
      refHead  = oldTail;
      refCount = flPkg::FreeListSize;
      heldTags.delete();
    end
    else
    begin
      refCount += pushes;
      if (popOk)
      begin
        refHead  = (refHead + pops) % flPkg::FreeListSize;
        refCount -= pops;
      end
    end
  endtask

  // inputs change at the rising edge, the DUT takes them at the next one
  task automatic driveCycle(input logic [flPkg::DispatchWidth-1:0] req, input logic stallIn,
                            input logic recIn, input logic [flPkg::CommitWidth-1:0] valid,
                            input logic [flPkg::CommitWidth-1:0][flPkg::PhysRegW-1:0] ids);
    @(posedge clk);
    reqPhyReg  <= req;
    stall      <= stallIn;
    recover    <= recIn;
    freedValid <= valid;
    freedRegId <= ids;
    @(negedge clk);
    compareToModel();
    advanceModel(req, stallIn, recIn, valid, ids);
  endtask

  // only tags that rename still holds may come back
  task automatic pickFrees(input logic [flPkg::CommitWidth-1:0] mask,
                           output logic [flPkg::CommitWidth-1:0] valid,
                           output logic [flPkg::CommitWidth-1:0][flPkg::PhysRegW-1:0] ids);
    valid = '0;
    for (int lane = 0; lane < flPkg::CommitWidth; lane++)
    begin
      // idle lanes carry junk that the compactor must drop
      ids[lane] = flPkg::PhysRegW'($random(seed));
      if (mask[lane] && heldTags.size() > 0)
      begin
        valid[lane] = 1'b1;
        ids[lane]   = heldTags.pop_front();
      end
    end
  endtask

  task automatic waitForReady();
    while (flRamReady !== 1'b1)
    begin
      @(posedge clk);
    end
  endtask

  task automatic reportTest(input string name, input int startErrors);
    int newErrors;
    newErrors = errorCount - startErrors;
    if (newErrors == 0)
    begin
      testsPassed++;
      $display("test %s: ok", name);
    end
    else
    begin
      testsFailed++;
      $display("test %s: %0d errors", name, newErrors);
    end
  endtask

  // sampled mid cycle after n rising edges, ready follows the idle cycle and one write per entry
  task automatic readyTimingTest();
    int startErrors;
    startErrors = errorCount;
    for (int n = 0; n <= flPkg::FreeListSize + 1; n++)
    begin
      @(negedge clk);
      checkFlag("flRamReady_o", flRamReady, (n == flPkg::FreeListSize + 1));
      checkFlag("freeListEmpty_o", freeListEmpty, 1'b0);
    end
    reportTest("ready timing", startErrors);
  endtask

  task automatic initContentsTest();
    int startErrors;
    startErrors = errorCount;
    waitForReady();
    for (int n = 0; n < 8; n++)
    begin
      driveCycle('1, 1'b0, 1'b0, '0, '0);
      for (int i = 0; i < flPkg::DispatchWidth; i++)
      begin
        checkTag($sformatf("freePhyReg_o[%0d]", i), freePhyReg[i],
                 flPkg::PhysRegW'(flPkg::NumArchRegs + flPkg::DispatchWidth * n + i));
      end
    end
    reportTest("init contents", startErrors);
  endtask

  task automatic emptyTest();
    int startErrors;
    startErrors = errorCount;
    waitForReady();
    // the last four pops land here, then requests must bounce
    repeat (4)
    begin
      driveCycle('1, 1'b0, 1'b0, '0, '0);
      checkFlag("freeListEmpty_o", freeListEmpty, 1'b1);
      for (int i = 0; i < flPkg::DispatchWidth; i++)
      begin
        checkTag($sformatf("freePhyReg_o[%0d]", i), freePhyReg[i], '0);
      end
    end
    reportTest("empty", startErrors);
  endtask

  task automatic compactedFreeTest();
    int                                                 startErrors;
    logic [flPkg::CommitWidth-1:0]                      mask;
    logic [flPkg::CommitWidth-1:0]                      valid;
    logic [flPkg::CommitWidth-1:0][flPkg::PhysRegW-1:0] ids;
    logic [flPkg::PhysRegW-1:0]                         freedOrder [$];
    startErrors = errorCount;
    waitForReady();
    while (freedOrder.size() < 12)
    begin
      mask = flPkg::CommitWidth'($random(seed));
      pickFrees(mask, valid, ids);
      for (int lane = 0; lane < flPkg::CommitWidth; lane++)
      begin
        if (valid[lane])
        begin
          freedOrder.push_back(ids[lane]);
        end
      end
      driveCycle('0, 1'b0, 1'b0, valid, ids);
    end
    // tags come back out in the order they were freed
    while (freedOrder.size() >= flPkg::DispatchWidth)
    begin
      driveCycle('1, 1'b0, 1'b0, '0, '0);
      checkFlag("freeListEmpty_o", freeListEmpty, 1'b0);
      for (int i = 0; i < flPkg::DispatchWidth; i++)
      begin
        checkTag($sformatf("freePhyReg_o[%0d]", i), freePhyReg[i], freedOrder.pop_front());
      end
    end
    reportTest("compacted free", startErrors);
  endtask

  task automatic stallTest();
    int                                                   startErrors;
    logic [flPkg::CommitWidth-1:0]                        valid;
    logic [flPkg::CommitWidth-1:0][flPkg::PhysRegW-1:0]   ids;
    logic [flPkg::DispatchWidth-1:0][flPkg::PhysRegW-1:0] offered;
    startErrors = errorCount;
    waitForReady();
    repeat (2)
    begin
      pickFrees('1, valid, ids);
      driveCycle('0, 1'b0, 1'b0, valid, ids);
    end
    pickFrees('1, valid, ids);
    driveCycle('1, 1'b1, 1'b0, valid, ids);
    checkFlag("freeListEmpty_o", freeListEmpty, 1'b0);
    // the stalled head keeps offering these
    for (int i = 0; i < flPkg::DispatchWidth; i++)
    begin
      offered[i] = refMem[(refHead + i) % flPkg::FreeListSize];
    end
    repeat (4)
    begin
      pickFrees('1, valid, ids);
      driveCycle('1, 1'b1, 1'b0, valid, ids);
      for (int i = 0; i < flPkg::DispatchWidth; i++)
      begin
        checkTag($sformatf("freePhyReg_o[%0d]", i), freePhyReg[i], offered[i]);
      end
    end
    driveCycle('0, 1'b0, 1'b0, '0, '0);
    for (int i = 0; i < flPkg::DispatchWidth; i++)
    begin
      checkTag($sformatf("freePhyReg_o[%0d]", i), freePhyReg[i], offered[i]);
    end
    reportTest("stall", startErrors);
  endtask

  task automatic recoverTest();
    int startErrors;
    int tailAtRecover;
    startErrors = errorCount;
    waitForReady();
    driveCycle('1, 1'b0, 1'b0, '0, '0);
    driveCycle('1, 1'b0, 1'b0, '0, '0);
    tailAtRecover = refTail;
    driveCycle('0, 1'b0, 1'b1, '0, '0);
    driveCycle('0, 1'b0, 1'b0, '0, '0);
    // head now sits on the old tail with a full list behind it
    checkFlag("freeListEmpty_o", freeListEmpty, 1'b0);
    for (int i = 0; i < flPkg::DispatchWidth; i++)
    begin
      checkTag($sformatf("freePhyReg_o[%0d]", i), freePhyReg[i],
               refMem[(tailAtRecover + i) % flPkg::FreeListSize]);
    end
    reportTest("recover", startErrors);
  endtask

  task automatic mixedTrafficTest();
    int                                                 startErrors;
    int                                                 lanes;
    logic [flPkg::DispatchWidth-1:0]                    req;
    logic                                               stallIn;
    logic [flPkg::CommitWidth-1:0]                      valid;
    logic [flPkg::CommitWidth-1:0][flPkg::PhysRegW-1:0] ids;
    startErrors = errorCount;
    waitForReady();
    repeat (150)
    begin
      lanes   = int'($unsigned($random(seed)) % (flPkg::DispatchWidth + 1));
      req     = flPkg::DispatchWidth'((1 << lanes) - 1);
      stallIn = (($random(seed) & 7) == 0);
      pickFrees(flPkg::CommitWidth'($random(seed)), valid, ids);
      driveCycle(req, stallIn, 1'b0, valid, ids);
    end
    driveCycle('0, 1'b0, 1'b0, '0, '0);
    reportTest("mixed traffic", startErrors);
  endtask

  initial
  begin
    cycleCount = 0;
    while (cycleCount < CycleLimit)
    begin
      @(posedge clk);
      cycleCount++;
    end
    $display("timeout after %0d cycles, the tests did not finish", CycleLimit);
    $display("Simulation failed");
    $finish;
  end

  initial
  begin
    clk         = 1'b0;
    reset       = 1'b1;
    stall       = 1'b0;
    recover     = 1'b0;
    reqPhyReg   = '0;
    freedValid  = '0;
    freedRegId  = '0;
    seed        = 32'h6c804d9e;
    errorCount  = 0;
    testsPassed = 0;
    testsFailed = 0;
    resetModel();
    repeat (4) @(posedge clk);
    reset <= 1'b0;
    readyTimingTest();
    initContentsTest();
    emptyTest();
    compactedFreeTest();
    stallTest();
    recoverTest();
    mixedTrafficTest();
    $display("tests passed %0d, tests failed %0d, check errors %0d",
             testsPassed, testsFailed, errorCount);
    if (testsFailed == 0 && errorCount == 0)
    begin
      $display("Simulation passed");
    end
    else
    begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- src/flInitSequencer.sv
module flInitSequencer
(
  input  logic                             clk,
  input  logic                             reset,
  output logic                             initWe_o,
  output logic [flPkg::FreeListIdxW-1:0]   initAddr_o,
  output logic [flPkg::PhysRegW-1:0]       initData_o,
  output logic                             ready_o
);

  logic [flPkg::InitStateW-1:0]   state;
  logic [flPkg::FreeListIdxW-1:0] addr;
  logic [flPkg::PhysRegW-1:0]     data;

  // one idle cycle, then one entry per cycle until the last slot is written
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      state <= flPkg::InitStart;
      addr  <= '0;
      data  <= flPkg::PhysRegW'(flPkg::NumArchRegs);
    end
    else
    begin
      case (state)
        flPkg::InitStart:
        begin
          state <= flPkg::InitRun;
          addr  <= '0;
          data  <= flPkg::PhysRegW'(flPkg::NumArchRegs);
        end
        flPkg::InitRun:
        begin
          addr <= addr + 1'b1;
          data <= data + 1'b1;
          if (addr == flPkg::FreeListIdxW'(flPkg::FreeListSize - 1))
          begin
            state <= flPkg::InitDone;
          end
        end
        flPkg::InitDone:
        begin
          state <= flPkg::InitDone;
        end
        default:
        begin
          state <= flPkg::InitDone;
        end
      endcase
    end
  end

  assign initWe_o   = (state == flPkg::InitRun);
  assign initAddr_o = addr;
  assign initData_o = data;
  assign ready_o    = (state == flPkg::InitDone);

endmodule

//--- src/flPkg.sv
package flPkg;

  // rename and commit lanes
  localparam int DispatchWidth = 4;
  localparam int CommitWidth   = 4;

  // list geometry, the size stays a power of two so pointers wrap for free
  localparam int FreeListSize  = 32;
  localparam int FreeListIdxW  = $clog2(FreeListSize);
  // one extra bit so a full list can be counted
  localparam int FreeListCntW  = FreeListIdxW + 1;

  // tags below this are held by the architectural map at reset
  localparam int NumArchRegs   = 32;
  localparam int PhysRegW      = 6;
  localparam int LaneCntW      = 3;

  // init sequencer states
  localparam int InitStateW = 2;
  localparam logic [InitStateW-1:0] InitStart = 2'd0;
  localparam logic [InitStateW-1:0] InitRun   = 2'd1;
  localparam logic [InitStateW-1:0] InitDone  = 2'd2;

endpackage

//--- src/flPointerControl.sv
module flPointerControl
(
  input  logic                               clk,
  input  logic                               reset,
  input  logic [flPkg::DispatchWidth-1:0]    reqPhyReg_i,
  input  logic                               stall_i,
  input  logic                               recover_i,
  input  logic [flPkg::LaneCntW-1:0]         pushCount_i,
  output logic [flPkg::FreeListIdxW-1:0]     head_o,
  output logic [flPkg::FreeListIdxW-1:0]     tail_o,
  output logic                               empty_o
);

  logic [flPkg::FreeListIdxW-1:0] head;
  logic [flPkg::FreeListIdxW-1:0] tail;
  logic [flPkg::FreeListCntW-1:0] count;
  logic [flPkg::FreeListCntW-1:0] countNext;
  logic [flPkg::LaneCntW-1:0]     popCount;
  logic                           popEn;

  // lanes request from lane 0 upward, so the bit count is the pop count
  always_comb
  begin
    popCount = '0;
    for (int i = 0; i < flPkg::DispatchWidth; i++)
    begin
      popCount = popCount + flPkg::LaneCntW'(reqPhyReg_i[i]);
    end
  end

  // fewer tags than lanes counts as empty
  assign empty_o = (count < flPkg::FreeListCntW'(flPkg::DispatchWidth));
  assign popEn   = ~stall_i & ~empty_o;

  always_comb
  begin
    countNext = count + flPkg::FreeListCntW'(pushCount_i);
    if (popEn)
    begin
      countNext = countNext - flPkg::FreeListCntW'(popCount);
    end
  end

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      head  <= '0;
      tail  <= '0;
      count <= flPkg::FreeListCntW'(flPkg::FreeListSize);
    end
    else
    begin
      // freed tags land even during recovery
      tail <= tail + flPkg::FreeListIdxW'(pushCount_i);
      if (recover_i)
      begin
        // everything past the tail is free again
        head  <= tail;
        count <= flPkg::FreeListCntW'(flPkg::FreeListSize);
      end
      else
      begin
        count <= countNext;
        if (popEn)
        begin
          head <= head + flPkg::FreeListIdxW'(popCount);
        end
      end
    end
  end

  assign head_o = head;
  assign tail_o = tail;

  // commit never frees more tags than rename has taken
  countBound: assert property (@(posedge clk) disable iff (reset)
    !recover_i |=> count <= flPkg::FreeListCntW'(flPkg::FreeListSize))
    else $error("free list count above list size");

endmodule

//--- src/flPushCompactor.sv
module flPushCompactor
(
  input  logic [flPkg::CommitWidth-1:0]                          freedValid_i,
  input  logic [flPkg::CommitWidth-1:0][flPkg::PhysRegW-1:0]     freedRegId_i,
  input  logic [flPkg::FreeListIdxW-1:0]                         tail_i,
  output logic [flPkg::CommitWidth-1:0]                          wrEn_o,
  output logic [flPkg::CommitWidth-1:0][flPkg::FreeListIdxW-1:0] wrAddr_o,
  output logic [flPkg::CommitWidth-1:0][flPkg::PhysRegW-1:0]     wrData_o,
  output logic [flPkg::LaneCntW-1:0]                             pushCount_o
);

  logic [flPkg::CommitWidth-1:0][flPkg::PhysRegW-1:0] packedData;
  logic [flPkg::LaneCntW-1:0]                         validCount;

  // walk the lanes in order, each valid tag lands in the next free slot
  always_comb
  begin
    logic [flPkg::LaneCntW-1:0] slot;
    slot       = '0;
    packedData = '0;
    for (int lane = 0; lane < flPkg::CommitWidth; lane++)
    begin
      if (freedValid_i[lane])
      begin
        packedData[slot] = freedRegId_i[lane];
        slot             = slot + 1'b1;
      end
    end
    validCount = slot;
  end

  // slots are consecutive from the tail, only the filled ones write
  always_comb
  begin
    for (int k = 0; k < flPkg::CommitWidth; k++)
    begin
      wrAddr_o[k] = tail_i + flPkg::FreeListIdxW'(k);
      wrEn_o[k]   = (flPkg::LaneCntW'(k) < validCount);
    end
  end

  assign wrData_o    = packedData;
  assign pushCount_o = validCount;

endmodule

//--- src/flStorage.sv
module flStorage
(
  input  logic                                                   clk,
  input  logic                                                   initWe_i,
  input  logic [flPkg::FreeListIdxW-1:0]                         initAddr_i,
  input  logic [flPkg::PhysRegW-1:0]                             initData_i,
  input  logic [flPkg::CommitWidth-1:0]                          wrEn_i,
  input  logic [flPkg::CommitWidth-1:0][flPkg::FreeListIdxW-1:0] wrAddr_i,
  input  logic [flPkg::CommitWidth-1:0][flPkg::PhysRegW-1:0]     wrData_i,
  input  logic [flPkg::FreeListIdxW-1:0]                         head_i,
  input  logic                                                   empty_i,
  output logic [flPkg::DispatchWidth-1:0][flPkg::PhysRegW-1:0]   freePhyReg_o
);

  logic [flPkg::PhysRegW-1:0] mem [flPkg::FreeListSize];

  // write port 0 is shared with the init sequencer
  logic [flPkg::CommitWidth-1:0][flPkg::FreeListIdxW-1:0] portAddr;
  logic [flPkg::CommitWidth-1:0][flPkg::PhysRegW-1:0]     portData;
  logic [flPkg::CommitWidth-1:0]                          portEn;

  always_comb
  begin
    portEn   = wrEn_i;
    portAddr = wrAddr_i;
    portData = wrData_i;
    if (initWe_i)
    begin
      portEn[0]   = 1'b1;
      portAddr[0] = initAddr_i;
      portData[0] = initData_i;
    end
  end

  always_ff @(posedge clk)
  begin
    for (int k = 0; k < flPkg::CommitWidth; k++)
    begin
      if (portEn[k])
      begin
        mem[portAddr[k]] <= portData[k];
      end
    end
  end

  // lane i reads head+i, the index wraps at the list size
  logic [flPkg::DispatchWidth-1:0][flPkg::FreeListIdxW-1:0] readAddr;

  always_comb
  begin
    for (int i = 0; i < flPkg::DispatchWidth; i++)
    begin
      readAddr[i] = head_i + flPkg::FreeListIdxW'(i);
      if (empty_i)
      begin
        freePhyReg_o[i] = '0;
      end
      else
      begin
        freePhyReg_o[i] = mem[readAddr[i]];
      end
    end
  end

  // commit must not return tags before the list has been filled
  initNoPush: assert property (@(posedge clk) initWe_i |-> !(|wrEn_i))
    else $error("free list push during init");

endmodule

//--- src/specFreeList.sv
module specFreeList
(
  input  logic                                                 clk,
  input  logic                                                 reset,
  input  logic                                                 stall_i,
  input  logic                                                 recover_i,
  input  logic [flPkg::DispatchWidth-1:0]                      reqPhyReg_i,
  input  logic [flPkg::CommitWidth-1:0]                        freedValid_i,
  input  logic [flPkg::CommitWidth-1:0][flPkg::PhysRegW-1:0]   freedRegId_i,
  output logic [flPkg::DispatchWidth-1:0][flPkg::PhysRegW-1:0] freePhyReg_o,
  output logic                                                 freeListEmpty_o,
  output logic                                                 flRamReady_o
);

  logic                                                   initWe;
  logic [flPkg::FreeListIdxW-1:0]                         initAddr;
  logic [flPkg::PhysRegW-1:0]                             initData;

  logic [flPkg::CommitWidth-1:0]                          wrEn;
  logic [flPkg::CommitWidth-1:0][flPkg::FreeListIdxW-1:0] wrAddr;
  logic [flPkg::CommitWidth-1:0][flPkg::PhysRegW-1:0]     wrData;
  logic [flPkg::LaneCntW-1:0]                             pushCount;

  logic [flPkg::FreeListIdxW-1:0]                         head;
  logic [flPkg::FreeListIdxW-1:0]                         tail;
  logic                                                   empty;

  flInitSequencer initSeq
  (
    .clk        (clk),
    .reset      (reset),
    .initWe_o   (initWe),
    .initAddr_o (initAddr),
    .initData_o (initData),
    .ready_o    (flRamReady_o)
  );

  flPushCompactor pushCompactor
  (
    .freedValid_i (freedValid_i),
    .freedRegId_i (freedRegId_i),
    .tail_i       (tail),
    .wrEn_o       (wrEn),
    .wrAddr_o     (wrAddr),
    .wrData_o     (wrData),
    .pushCount_o  (pushCount)
  );

  flStorage storage
  (
    .clk          (clk),
    .initWe_i     (initWe),
    .initAddr_i   (initAddr),
    .initData_i   (initData),
    .wrEn_i       (wrEn),
    .wrAddr_i     (wrAddr),
    .wrData_i     (wrData),
    .head_i       (head),
    .empty_i      (empty),
    .freePhyReg_o (freePhyReg_o)
  );

  flPointerControl pointerCtrl
  (
    .clk         (clk),
    .reset       (reset),
    .reqPhyReg_i (reqPhyReg_i),
    .stall_i     (stall_i),
    .recover_i   (recover_i),
    .pushCount_i (pushCount),
    .head_o      (head),
    .tail_o      (tail),
    .empty_o     (empty)
  );

  assign freeListEmpty_o = empty;

endmodule

//--- verilog.f
src/flPkg.sv
src/flInitSequencer.sv
src/flPushCompactor.sv
src/flStorage.sv
src/flPointerControl.sv
src/specFreeList.sv
sim/specFreeListTb.sv
